// ==== src/rv32i_types_pkg.sv ====
package rv32i_types_pkg;

    localparam int XLEN      = 32;
    localparam int ORDER_W   = 64;
    localparam int REG_IDX_W = 5;

    // alu operation as decoded from funct3/funct7
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_sll  = 4'b0010,
        alu_slt  = 4'b0011,
        alu_sltu = 4'b0100,
        alu_xor  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sra  = 4'b0111,
        alu_or   = 4'b1000,
        alu_and  = 4'b1001
    } alu_ops_t;

    // same code points as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_ops_t;

    typedef enum logic {
        rs1_v_alu_ex  = 1'b0,
        pc_out_alu_ex = 1'b1
    } alu_m1_sel_t;

    typedef enum logic [2:0] {
        i_imm_alu_ex = 3'b000,
        u_imm_alu_ex = 3'b001,
        b_imm_alu_ex = 3'b010,
        s_imm_alu_ex = 3'b011,
        j_imm_alu_ex = 3'b100,
        rs2_v_alu_ex = 3'b101
    } alu_m2_sel_t;

    typedef enum logic {
        rs2_v_cmp_ex = 1'b0,
        i_imm_cmp_ex = 1'b1
    } cmp_m_sel_t;

    // consumed by the memory stage
    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;
    } mem_signal_t;

    // consumed by writeback
    typedef struct packed {
        logic       regf_we;
        logic [2:0] wb_sel;
    } wb_signal_t;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu
import rv32i_types_pkg::*;
(
    input  alu_ops_t          aluop,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic [XLEN-1:0]   f
);

    logic signed [XLEN-1:0] as;
    logic signed [XLEN-1:0] bs;
    logic        [4:0]      shamt;

    assign as    = signed'(a);
    assign bs    = signed'(b);
    // only the low five bits count for shifts
    assign shamt = b[4:0];

    always_comb begin
        f = '0;
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {{(XLEN-1){1'b0}}, (as < bs)};
            alu_sltu: f = {{(XLEN-1){1'b0}}, (a < b)};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = unsigned'(as >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule

// ==== src/cmp.sv ====
`timescale 1ns/1ps

module cmp
import rv32i_types_pkg::*;
(
    input  cmp_ops_t          cmpop,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic              br_en
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (a == b);
    assign lt  = (signed'(a) < signed'(b));
    assign ltu = (a < b);

    always_comb begin
        br_en = 1'b0;
        case (cmpop)
            cmp_beq:  br_en = eq;
            cmp_bne:  br_en = ~eq;
            cmp_blt:  br_en = lt;
            cmp_bge:  br_en = ~lt;
            cmp_bltu: br_en = ltu;
            cmp_bgeu: br_en = ~ltu;
            default:  br_en = 1'b0;
        endcase
    end

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
import rv32i_types_pkg::*;
(
    input  logic                   valid,
    input  logic [XLEN-1:0]        inst,
    input  logic [XLEN-1:0]        pc,
    input  logic [ORDER_W-1:0]     order,
    input  alu_m1_sel_t            alu_m1_sel,
    input  alu_m2_sel_t            alu_m2_sel,
    input  cmp_m_sel_t             cmp_m_sel,
    input  alu_ops_t               alu_ops,
    input  cmp_ops_t               cmp_ops,
    input  mem_signal_t            mem_signal,
    input  wb_signal_t             wb_signal,
    input  logic [XLEN-1:0]        i_imm,
    input  logic [XLEN-1:0]        s_imm,
    input  logic [XLEN-1:0]        b_imm,
    input  logic [XLEN-1:0]        u_imm,
    input  logic [XLEN-1:0]        j_imm,
    input  logic [XLEN-1:0]        rs1_v,
    input  logic [XLEN-1:0]        rs2_v,
    input  logic [REG_IDX_W-1:0]   rs1_s,
    input  logic [REG_IDX_W-1:0]   rs2_s,
    input  logic [REG_IDX_W-1:0]   rd_s,

    output logic                   ex_valid,
    output logic [XLEN-1:0]        ex_inst,
    output logic [XLEN-1:0]        ex_pc,
    output logic [ORDER_W-1:0]     ex_order,
    output mem_signal_t            ex_mem_signal,
    output wb_signal_t             ex_wb_signal,
    output logic [XLEN-1:0]        ex_alu_out,
    output logic [XLEN-1:0]        ex_br_en,
    output logic [XLEN-1:0]        ex_u_imm,
    output logic [XLEN-1:0]        ex_rs1_v,
    output logic [XLEN-1:0]        ex_rs2_v,
    output logic [REG_IDX_W-1:0]   ex_rs1_s,
    output logic [REG_IDX_W-1:0]   ex_rs2_s,
    output logic [REG_IDX_W-1:0]   ex_rd_s
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] cmp_b;
    logic [XLEN-1:0] alu_f;
    logic            cmp_br;

    // pc operand for auipc and jal
    always_comb begin
        alu_a = rs1_v;
        case (alu_m1_sel)
            rs1_v_alu_ex:  alu_a = rs1_v;
            pc_out_alu_ex: alu_a = pc;
            default:       alu_a = rs1_v;
        endcase
    end

    always_comb begin
        alu_b = '0;
        case (alu_m2_sel)
            i_imm_alu_ex: alu_b = i_imm;
            u_imm_alu_ex: alu_b = u_imm;
            b_imm_alu_ex: alu_b = b_imm;
            s_imm_alu_ex: alu_b = s_imm;
            j_imm_alu_ex: alu_b = j_imm;
            rs2_v_alu_ex: alu_b = rs2_v;
            default:      alu_b = '0;
        endcase
    end

    // i_imm here serves slti/sltiu
    assign cmp_b = (cmp_m_sel == i_imm_cmp_ex) ? i_imm : rs2_v;

    alu u_alu (
        .aluop (alu_ops),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    cmp u_cmp (
        .cmpop (cmp_ops),
        .a     (rs1_v),
        .b     (cmp_b),
        .br_en (cmp_br)
    );

    assign ex_alu_out    = alu_f;
    assign ex_br_en      = {{(XLEN-1){1'b0}}, cmp_br};

    // pass-through to the memory stage
    assign ex_valid      = valid;
    assign ex_inst       = inst;
    assign ex_pc         = pc;
    assign ex_order      = order;
    assign ex_mem_signal = mem_signal;
    assign ex_wb_signal  = wb_signal;
    assign ex_u_imm      = u_imm;
    assign ex_rs1_v      = rs1_v;
    assign ex_rs2_v      = rs2_v;
    assign ex_rs1_s      = rs1_s;
    assign ex_rs2_s      = rs2_s;
    assign ex_rd_s       = rd_s;

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg
import rv32i_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,

    input  logic                   d_valid,
    input  logic [XLEN-1:0]        d_inst,
    input  logic [XLEN-1:0]        d_pc,
    input  logic [ORDER_W-1:0]     d_order,
    input  mem_signal_t            d_mem_signal,
    input  wb_signal_t             d_wb_signal,
    input  logic [XLEN-1:0]        d_alu_out,
    input  logic [XLEN-1:0]        d_br_en,
    input  logic [XLEN-1:0]        d_u_imm,
    input  logic [XLEN-1:0]        d_rs1_v,
    input  logic [XLEN-1:0]        d_rs2_v,
    input  logic [REG_IDX_W-1:0]   d_rs1_s,
    input  logic [REG_IDX_W-1:0]   d_rs2_s,
    input  logic [REG_IDX_W-1:0]   d_rd_s,

    output logic                   q_valid,
    output logic [XLEN-1:0]        q_inst,
    output logic [XLEN-1:0]        q_pc,
    output logic [ORDER_W-1:0]     q_order,
    output mem_signal_t            q_mem_signal,
    output wb_signal_t             q_wb_signal,
    output logic [XLEN-1:0]        q_alu_out,
    output logic [XLEN-1:0]        q_br_en,
    output logic [XLEN-1:0]        q_u_imm,
    output logic [XLEN-1:0]        q_rs1_v,
    output logic [XLEN-1:0]        q_rs2_v,
    output logic [REG_IDX_W-1:0]   q_rs1_s,
    output logic [REG_IDX_W-1:0]   q_rs2_s,
    output logic [REG_IDX_W-1:0]   q_rd_s
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid      <= 1'b0;
            q_inst       <= '0;
            q_pc         <= '0;
            q_order      <= '0;
            q_mem_signal <= '0;
            q_wb_signal  <= '0;
            q_alu_out    <= '0;
            q_br_en      <= '0;
            q_u_imm      <= '0;
            q_rs1_v      <= '0;
            q_rs2_v      <= '0;
            q_rs1_s      <= '0;
            q_rs2_s      <= '0;
            q_rd_s       <= '0;
        end else if (!stall) begin
            // flush only kills the slot while data still loads
            q_valid      <= d_valid & ~flush;
            q_inst       <= d_inst;
            q_pc         <= d_pc;
            q_order      <= d_order;
            q_mem_signal <= d_mem_signal;
            q_wb_signal  <= d_wb_signal;
            q_alu_out    <= d_alu_out;
            q_br_en      <= d_br_en;
            q_u_imm      <= d_u_imm;
            q_rs1_v      <= d_rs1_v;
            q_rs2_v      <= d_rs2_v;
            q_rs1_s      <= d_rs1_s;
            q_rs2_s      <= d_rs2_s;
            q_rd_s       <= d_rd_s;
        end
    end

endmodule

// ==== src/ex_top.sv ====
`timescale 1ns/1ps

module ex_top
import rv32i_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,

    input  logic                   valid,
    input  logic [XLEN-1:0]        inst,
    input  logic [XLEN-1:0]        pc,
    input  logic [ORDER_W-1:0]     order,
    input  alu_m1_sel_t            alu_m1_sel,
    input  alu_m2_sel_t            alu_m2_sel,
    input  cmp_m_sel_t             cmp_m_sel,
    input  alu_ops_t               alu_ops,
    input  cmp_ops_t               cmp_ops,
    input  mem_signal_t            mem_signal,
    input  wb_signal_t             wb_signal,
    input  logic [XLEN-1:0]        i_imm,
    input  logic [XLEN-1:0]        s_imm,
    input  logic [XLEN-1:0]        b_imm,
    input  logic [XLEN-1:0]        u_imm,
    input  logic [XLEN-1:0]        j_imm,
    input  logic [XLEN-1:0]        rs1_v,
    input  logic [XLEN-1:0]        rs2_v,
    input  logic [REG_IDX_W-1:0]   rs1_s,
    input  logic [REG_IDX_W-1:0]   rs2_s,
    input  logic [REG_IDX_W-1:0]   rd_s,

    output logic                   ex_valid,
    output logic [XLEN-1:0]        ex_inst,
    output logic [XLEN-1:0]        ex_pc,
    output logic [ORDER_W-1:0]     ex_order,
    output mem_signal_t            ex_mem_signal,
    output wb_signal_t             ex_wb_signal,
    output logic [XLEN-1:0]        ex_alu_out,
    output logic [XLEN-1:0]        ex_br_en,
    output logic [XLEN-1:0]        ex_u_imm,
    output logic [XLEN-1:0]        ex_rs1_v,
    output logic [XLEN-1:0]        ex_rs2_v,
    output logic [REG_IDX_W-1:0]   ex_rs1_s,
    output logic [REG_IDX_W-1:0]   ex_rs2_s,
    output logic [REG_IDX_W-1:0]   ex_rd_s
);

    // combinational execute result ahead of the boundary
    logic                  res_valid;
    logic [XLEN-1:0]       res_inst;
    logic [XLEN-1:0]       res_pc;
    logic [ORDER_W-1:0]    res_order;
    mem_signal_t           res_mem_signal;
    wb_signal_t            res_wb_signal;
    logic [XLEN-1:0]       res_alu_out;
    logic [XLEN-1:0]       res_br_en;
    logic [XLEN-1:0]       res_u_imm;
    logic [XLEN-1:0]       res_rs1_v;
    logic [XLEN-1:0]       res_rs2_v;
    logic [REG_IDX_W-1:0]  res_rs1_s;
    logic [REG_IDX_W-1:0]  res_rs2_s;
    logic [REG_IDX_W-1:0]  res_rd_s;

    ex_stage u_ex_stage (
        .valid         (valid),          .inst          (inst),
        .pc            (pc),             .order         (order),
        .alu_m1_sel    (alu_m1_sel),     .alu_m2_sel    (alu_m2_sel),
        .cmp_m_sel     (cmp_m_sel),      .alu_ops       (alu_ops),
        .cmp_ops       (cmp_ops),        .mem_signal    (mem_signal),
        .wb_signal     (wb_signal),      .i_imm         (i_imm),
        .s_imm         (s_imm),          .b_imm         (b_imm),
        .u_imm         (u_imm),          .j_imm         (j_imm),
        .rs1_v         (rs1_v),          .rs2_v         (rs2_v),
        .rs1_s         (rs1_s),          .rs2_s         (rs2_s),
        .rd_s          (rd_s),
        .ex_valid      (res_valid),      .ex_inst       (res_inst),
        .ex_pc         (res_pc),         .ex_order      (res_order),
        .ex_mem_signal (res_mem_signal), .ex_wb_signal  (res_wb_signal),
        .ex_alu_out    (res_alu_out),    .ex_br_en      (res_br_en),
        .ex_u_imm      (res_u_imm),      .ex_rs1_v      (res_rs1_v),
        .ex_rs2_v      (res_rs2_v),      .ex_rs1_s      (res_rs1_s),
        .ex_rs2_s      (res_rs2_s),      .ex_rd_s       (res_rd_s)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk          (clk),            .rst          (rst),
        .stall        (stall),          .flush        (flush),
        .d_valid      (res_valid),      .d_inst       (res_inst),
        .d_pc         (res_pc),         .d_order      (res_order),
        .d_mem_signal (res_mem_signal), .d_wb_signal  (res_wb_signal),
        .d_alu_out    (res_alu_out),    .d_br_en      (res_br_en),
        .d_u_imm      (res_u_imm),      .d_rs1_v      (res_rs1_v),
        .d_rs2_v      (res_rs2_v),      .d_rs1_s      (res_rs1_s),
        .d_rs2_s      (res_rs2_s),      .d_rd_s       (res_rd_s),
        .q_valid      (ex_valid),       .q_inst       (ex_inst),
        .q_pc         (ex_pc),          .q_order      (ex_order),
        .q_mem_signal (ex_mem_signal),  .q_wb_signal  (ex_wb_signal),
        .q_alu_out    (ex_alu_out),     .q_br_en      (ex_br_en),
        .q_u_imm      (ex_u_imm),       .q_rs1_v      (ex_rs1_v),
        .q_rs2_v      (ex_rs2_v),       .q_rs1_s      (ex_rs1_s),
        .q_rs2_s      (ex_rs2_s),       .q_rd_s       (ex_rd_s)
    );

endmodule

// ==== verif/tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top
import rv32i_types_pkg::*;
();

    typedef struct {
        string                name;
        logic                 valid;
        logic                 stall;
        logic                 flush;
        alu_m1_sel_t          m1_sel;
        alu_m2_sel_t          m2_sel;
        cmp_m_sel_t           cmp_sel;
        alu_ops_t             aop;
        cmp_ops_t             cop;
        logic [XLEN-1:0]      inst;
        logic [XLEN-1:0]      pc;
        logic [ORDER_W-1:0]   order;
        mem_signal_t          mem;
        wb_signal_t           wb;
        logic [XLEN-1:0]      i_imm;
        logic [XLEN-1:0]      s_imm;
        logic [XLEN-1:0]      b_imm;
        logic [XLEN-1:0]      u_imm;
        logic [XLEN-1:0]      j_imm;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
        logic [REG_IDX_W-1:0] rs1_s;
        logic [REG_IDX_W-1:0] rs2_s;
        logic [REG_IDX_W-1:0] rd_s;
        logic [XLEN-1:0]      exp_alu;
        logic                 exp_br;
        logic                 exp_valid;
    } vec_t;

    logic clk, rst, stall, flush, valid;
    logic [XLEN-1:0] inst, pc, i_imm, s_imm, b_imm, u_imm, j_imm, rs1_v, rs2_v;
    logic [ORDER_W-1:0] order;
    alu_m1_sel_t alu_m1_sel;
    alu_m2_sel_t alu_m2_sel;
    cmp_m_sel_t cmp_m_sel;
    alu_ops_t alu_ops;
    cmp_ops_t cmp_ops;
    mem_signal_t mem_signal, ex_mem_signal;
    wb_signal_t wb_signal, ex_wb_signal;
    logic [REG_IDX_W-1:0] rs1_s, rs2_s, rd_s, ex_rs1_s, ex_rs2_s, ex_rd_s;
    logic ex_valid;
    logic [XLEN-1:0] ex_inst, ex_pc, ex_alu_out, ex_br_en, ex_u_imm, ex_rs1_v, ex_rs2_v;
    logic [ORDER_W-1:0] ex_order;

    vec_t tbl[$];
    int   cycles = 0;
    int   cycle_limit = 1000;
    int   last = 0;

    ex_top i_ex_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            report_failure("timeout: the vector table did not finish in time");
    end

    // reference model straight from the RV32I rules
    function automatic logic [XLEN-1:0] ref_alu(alu_ops_t op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic ref_cmp(cmp_ops_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return $signed(a) < $signed(b);
            cmp_bge:  return $signed(a) >= $signed(b);
            cmp_bltu: return a < b;
            cmp_bgeu: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic vec_t random_vec(string name);
        vec_t v;
        logic [XLEN-1:0] r;
        v.name = name;
        v.valid = 1'b1;
        v.stall = 1'b0;
        v.flush = 1'b0;
        v.m1_sel = rs1_v_alu_ex;
        v.m2_sel = rs2_v_alu_ex;
        v.cmp_sel = rs2_v_cmp_ex;
        v.aop = alu_add;
        v.cop = cmp_beq;
        v.inst = $urandom;
        v.pc = $urandom;
        v.order = {$urandom, $urandom};
        v.i_imm = $urandom;
        v.s_imm = $urandom;
        v.b_imm = $urandom;
        v.u_imm = $urandom;
        v.j_imm = $urandom;
        v.rs1 = $urandom;
        v.rs2 = $urandom;
        r = $urandom;
        v.rs1_s = r[4:0];
        v.rs2_s = r[9:5];
        v.rd_s = r[14:10];
        v.mem = r[19:15];
        v.wb = r[23:20];
        return v;
    endfunction

    task automatic push_vec(vec_t v);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] cb;
        vec_t prev;
        if (v.stall) begin
            // a held register keeps what the previous entry left
            prev = tbl[tbl.size()-1];
            v.exp_alu = prev.exp_alu;
            v.exp_br = prev.exp_br;
            v.exp_valid = prev.exp_valid;
        end else begin
            a = (v.m1_sel == pc_out_alu_ex) ? v.pc : v.rs1;
            case (v.m2_sel)
                i_imm_alu_ex: b = v.i_imm;
                u_imm_alu_ex: b = v.u_imm;
                b_imm_alu_ex: b = v.b_imm;
                s_imm_alu_ex: b = v.s_imm;
                j_imm_alu_ex: b = v.j_imm;
                default:      b = v.rs2;
            endcase
            cb = (v.cmp_sel == i_imm_cmp_ex) ? v.i_imm : v.rs2;
            v.exp_alu = ref_alu(v.aop, a, b);
            v.exp_br = ref_cmp(v.cop, v.rs1, cb);
            v.exp_valid = v.valid & ~v.flush;
        end
        tbl.push_back(v);
    endtask

    task automatic build_table();
        vec_t v;
        alu_ops_t aops[10];
        cmp_ops_t cops[6];
        aops = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                 alu_xor, alu_srl, alu_sra, alu_or, alu_and};
        cops = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
        foreach (aops[k]) begin
            v = random_vec($sformatf("alu_%s", aops[k].name()));
            v.aop = aops[k];
            push_vec(v);
        end
        v = random_vec("auipc_pc_u_imm");
        v.m1_sel = pc_out_alu_ex;
        v.m2_sel = u_imm_alu_ex;
        push_vec(v);
        v = random_vec("pc_j_imm");
        v.m1_sel = pc_out_alu_ex;
        v.m2_sel = j_imm_alu_ex;
        push_vec(v);
        v = random_vec("pc_b_imm");
        v.m1_sel = pc_out_alu_ex;
        v.m2_sel = b_imm_alu_ex;
        push_vec(v);
        v = random_vec("rs1_s_imm");
        v.m2_sel = s_imm_alu_ex;
        push_vec(v);
        v = random_vec("rs1_i_imm");
        v.m2_sel = i_imm_alu_ex;
        push_vec(v);
        foreach (cops[k]) begin
            v = random_vec($sformatf("%s_rs2", cops[k].name()));
            v.cop = cops[k];
            push_vec(v);
            v = random_vec($sformatf("%s_imm", cops[k].name()));
            v.cop = cops[k];
            v.cmp_sel = i_imm_cmp_ex;
            push_vec(v);
            v = random_vec($sformatf("%s_equal", cops[k].name()));
            v.cop = cops[k];
            v.rs2 = v.rs1;
            push_vec(v);
            // only the sign bit differs from rs1
            v = random_vec($sformatf("%s_sign", cops[k].name()));
            v.cop = cops[k];
            v.cmp_sel = i_imm_cmp_ex;
            v.i_imm = v.rs1 ^ 32'h8000_0000;
            push_vec(v);
        end
        v = random_vec("before_stall");
        push_vec(v);
        v = random_vec("stall_hold");
        v.stall = 1'b1;
        push_vec(v);
        v = random_vec("stall_hold_again");
        v.stall = 1'b1;
        v.valid = 1'b0;
        push_vec(v);
        v = random_vec("flush_kill");
        v.flush = 1'b1;
        v.aop = alu_sub;
        push_vec(v);
        v = random_vec("reload");
        v.aop = alu_xor;
        push_vec(v);
        v = random_vec("flush_under_stall");
        v.stall = 1'b1;
        v.flush = 1'b1;
        push_vec(v);
    endtask

    task automatic drive_inputs(vec_t v);
        valid <= v.valid;
        stall <= v.stall;
        flush <= v.flush;
        alu_m1_sel <= v.m1_sel;
        alu_m2_sel <= v.m2_sel;
        cmp_m_sel <= v.cmp_sel;
        alu_ops <= v.aop;
        cmp_ops <= v.cop;
        inst <= v.inst;
        pc <= v.pc;
        order <= v.order;
        mem_signal <= v.mem;
        wb_signal <= v.wb;
        i_imm <= v.i_imm;
        s_imm <= v.s_imm;
        b_imm <= v.b_imm;
        u_imm <= v.u_imm;
        j_imm <= v.j_imm;
        rs1_v <= v.rs1;
        rs2_v <= v.rs2;
        rs1_s <= v.rs1_s;
        rs2_s <= v.rs2_s;
        rd_s <= v.rd_s;
    endtask

    task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp)
            report_failure($sformatf("Fail %s: alu_out expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_br(string name, logic exp, logic [XLEN-1:0] act);
        if (act !== {{(XLEN-1){1'b0}}, exp})
            report_failure($sformatf("Fail %s: br_en expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_valid(string name, logic exp, logic act);
        if (act !== exp)
            report_failure($sformatf("Fail %s: valid expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_pass(string name, vec_t e);
        if ({ex_inst, ex_pc, ex_order, ex_mem_signal, ex_wb_signal, ex_u_imm, ex_rs1_v,
             ex_rs2_v, ex_rs1_s, ex_rs2_s, ex_rd_s} !==
            {e.inst, e.pc, e.order, e.mem, e.wb, e.u_imm, e.rs1, e.rs2,
             e.rs1_s, e.rs2_s, e.rd_s})
            report_failure($sformatf("Fail %s: pass-through expected %h, actual %h", name,
                {e.inst, e.pc, e.order, e.mem, e.wb, e.u_imm, e.rs1, e.rs2,
                 e.rs1_s, e.rs2_s, e.rd_s},
                {ex_inst, ex_pc, ex_order, ex_mem_signal, ex_wb_signal, ex_u_imm, ex_rs1_v,
                 ex_rs2_v, ex_rs1_s, ex_rs2_s, ex_rd_s}));
    endtask

    initial begin
        void'($urandom(34532));
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        valid = 1'b0;
        alu_m1_sel = rs1_v_alu_ex;
        alu_m2_sel = i_imm_alu_ex;
        cmp_m_sel = rs2_v_cmp_ex;
        alu_ops = alu_add;
        cmp_ops = cmp_beq;
        mem_signal = '0;
        wb_signal = '0;
        {inst, pc, order, i_imm, s_imm, b_imm, u_imm, j_imm} = '0;
        {rs1_v, rs2_v, rs1_s, rs2_s, rd_s} = '0;
        build_table();
        cycle_limit = tbl.size() * 4 + 50;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_valid("after_reset", 1'b0, ex_valid);
        check_word("after_reset", '0, ex_alu_out);
        // one entry per two cycles with results one edge after launch
        foreach (tbl[i]) begin
            @(posedge clk);
            drive_inputs(tbl[i]);
            @(posedge clk);
            @(negedge clk);
            if (!tbl[i].stall)
                last = i;
            check_word(tbl[i].name, tbl[i].exp_alu, ex_alu_out);
            check_br(tbl[i].name, tbl[i].exp_br, ex_br_en);
            check_valid(tbl[i].name, tbl[i].exp_valid, ex_valid);
            check_pass(tbl[i].name, tbl[last]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/rv32i_types_pkg.sv
src/alu.sv
src/cmp.sv
src/ex_stage.sv
src/ex_mem_reg.sv
src/ex_top.sv
verif/tb_ex_top.sv

// ==== Bender.yml ====
package:
  name: rv32i_ex

sources:
  - files:
      - src/rv32i_types_pkg.sv
      - src/alu.sv
      - src/cmp.sv
      - src/ex_stage.sv
      - src/ex_mem_reg.sv
      - src/ex_top.sv
  - target: test
    files:
      - verif/tb_ex_top.sv
